/* pc_glue_pkg.sv */
package pc_glue_pkg;

   // expansion I/O address, xa[9:0], seen whole or as block + offset
   typedef union packed {
      logic [9:0] raw;
      struct packed {
         logic [4:0] blk;   // xa[9:5], one block per 32 ports
         logic [4:0] ofs;   // xa[4:0]
      } split;
   } io_addr_u;

   // I/O blocks still on the board
   localparam logic [4:0] IO_BLK_TIMER = 5'd2;   // 040h-05Fh
   localparam logic [4:0] IO_BLK_PPI   = 5'd3;   // 060h-07Fh
   localparam logic [4:0] IO_BLK_NMI   = 5'd5;   // 0A0h-0BFh

   // PPI port offsets inside the block
   localparam logic [1:0] PORT_A_OFS = 2'd0;
   localparam logic [1:0] PORT_B_OFS = 2'd1;
   localparam logic [1:0] PORT_C_OFS = 2'd2;

   // timer channel 2 data port, 042h
   localparam logic [1:0] TIMER2_OFS = 2'd2;

   // port B bits
   localparam int PB_TIM2_GATE  = 0;
   localparam int PB_SPKR_DATA  = 1;
   localparam int PB_SW_HI_SEL  = 2;
   localparam int PB_ENB_PCK_N  = 4;   // active low, 1 disables and clears
   localparam int PB_ENB_IOCK_N = 5;

   // port C status bits
   localparam int PC_TIM2_OUT = 5;
   localparam int PC_IOCK     = 6;
   localparam int PC_PCK      = 7;

   // data bit that holds the NMI mask on a write to 0A0h
   localparam int NMI_MASK_BIT = 7;

   // memory map
   localparam logic [3:0] ROM_SEG      = 4'hF;    // F0000h-FFFFFh
   localparam logic [1:0] RAM_SEG_BITS = 2'b00;   // first 256K on the board

endpackage

/* addr_decoder.sv */
`timescale 1ns/1ps

module addr_decoder
   import pc_glue_pkg::*;
(
   input  io_addr_u    xa_i,
   input  logic [19:0] mem_a_i,
   input  logic        memr_i,
   input  logic        memw_i,
   output logic        timer_sel_o,
   output logic        ppi_sel_o,
   output logic        nmi_sel_o,
   output logic [1:0]  ofs_o,
   output logic [7:0]  rom_cs_n_o,
   output logic [3:0]  ram_ras_n_o
);

   // block decode, DMA (0) and PIC (1) blocks fall through to nothing
   assign timer_sel_o = (xa_i.split.blk == IO_BLK_TIMER);
   assign ppi_sel_o   = (xa_i.split.blk == IO_BLK_PPI);
   assign nmi_sel_o   = (xa_i.split.blk == IO_BLK_NMI);

   assign ofs_o = xa_i.split.ofs[1:0];   // a1:a0 picks the port

   // one 8K ROM socket per a[15:13]
   always_comb begin
      rom_cs_n_o = 8'hFF;
      if (mem_a_i[19:16] == ROM_SEG && memr_i) begin
         rom_cs_n_o[mem_a_i[15:13]] = 1'b0;
      end
   end

   // 64K RAM banks, row strobe on any memory cycle in the low 256K
   always_comb begin
      ram_ras_n_o = 4'hF;
      if (mem_a_i[19:18] == RAM_SEG_BITS && (memr_i || memw_i)) begin
         ram_ras_n_o[mem_a_i[17:16]] = 1'b0;
      end
   end

endmodule

/* nmi_control.sv */
`timescale 1ns/1ps

module nmi_control
   import pc_glue_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  logic       sel_i,
   input  logic       iow_i,
   input  logic [7:0] wdata_i,
   input  logic       io_ch_ck_n_i,
   input  logic       parity_err_i,
   input  logic       memr_i,
   input  logic       enb_iock_n_i,
   input  logic       enb_pck_n_i,
   output logic       nmi_o,
   output logic       iock_flag_o,
   output logic       pck_flag_o
);

   logic nmi_mask_q;

   // write to 0A0h, only d7 matters
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         nmi_mask_q <= 1'b0;
      end else if (sel_i && iow_i) begin
         nmi_mask_q <= wdata_i[NMI_MASK_BIT];
      end
   end

   // channel check latch, held until port B disables it
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         iock_flag_o <= 1'b0;
      end else if (enb_iock_n_i) begin
         iock_flag_o <= 1'b0;
      end else if (!io_ch_ck_n_i) begin
         iock_flag_o <= 1'b1;
      end
   end

   // parity error only counts on a read cycle
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pck_flag_o <= 1'b0;
      end else if (enb_pck_n_i) begin
         pck_flag_o <= 1'b0;
      end else if (parity_err_i && memr_i) begin
         pck_flag_o <= 1'b1;
      end
   end

   assign nmi_o = nmi_mask_q && (iock_flag_o || pck_flag_o);

   // clearing the mask takes NMI away on the next cycle whatever the flags do
   mask_kills_nmi: assert property (@(posedge clk) disable iff (!reset_n)
      sel_i && iow_i && !wdata_i[NMI_MASK_BIT] |=> !nmi_o);

endmodule

/* system_ports.sv */
`timescale 1ns/1ps

module system_ports
   import pc_glue_pkg::*;
#(
   parameter logic [7:0] SW1 = 8'h00,
   parameter logic [3:0] SW2 = 4'h0
) (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       sel_i,
   input  logic       iow_i,
   input  logic [1:0] ofs_i,
   input  logic [7:0] wdata_i,
   input  logic       tim2_out_i,
   input  logic       iock_flag_i,
   input  logic       pck_flag_i,
   output logic [7:0] port_b_o,
   output logic [7:0] rdata_o
);

   logic [7:0] port_b_q;
   logic [7:0] port_c;

   // port B, 061h
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         port_b_q <= 8'h00;   // both checks enabled
      end else if (sel_i && iow_i && ofs_i == PORT_B_OFS) begin
         port_b_q <= wdata_i;
      end
   end

   assign port_b_o = port_b_q;

   // port C, switch nibble muxed by pb2, status on top
   always_comb begin
      port_c = 8'h00;   // bit 4 was cassette data in
      if (port_b_q[PB_SW_HI_SEL]) begin
         port_c[1:0] = SW2[3:2];
      end else begin
         port_c[1:0] = SW2[1:0];
      end
      port_c[PC_TIM2_OUT] = tim2_out_i;
      port_c[PC_IOCK]     = iock_flag_i;
      port_c[PC_PCK]      = pck_flag_i;
   end

   // read path, no keyboard so port A is always SW1
   always_comb begin
      case (ofs_i)
         PORT_A_OFS: rdata_o = SW1;
         PORT_B_OFS: rdata_o = port_b_q;
         PORT_C_OFS: rdata_o = port_c;
         default:    rdata_o = 8'h00;   // mode word port, write only
      endcase
   end

   // a port B write shows up the cycle after the strobe
   pb_write_lands: assert property (@(posedge clk) disable iff (!reset_n)
      sel_i && iow_i && ofs_i == PORT_B_OFS |=> port_b_o == $past(wdata_i));

endmodule

/* speaker_timer.sv */
`timescale 1ns/1ps

module speaker_timer
   import pc_glue_pkg::*;
#(
   parameter int TICK_DIV = 4
) (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       sel_i,
   input  logic       iow_i,
   input  logic [1:0] ofs_i,
   input  logic [7:0] wdata_i,
   input  logic       gate_i,
   input  logic       spkr_data_i,
   output logic       tim2_out_o,
   output logic       speaker_o
);

   localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   logic [PW-1:0] pre_q;
   logic          tick;        // stands in for the divided timer clock
   logic          wr;
   logic          hi_next_q;   // byte pointer, low byte first
   logic          load_pend_q;
   logic [15:0]   reload_q;
   logic [15:0]   cnt_q;

   // prescaler
   assign tick = (pre_q == PW'(TICK_DIV - 1));

   always_ff @(posedge clk) begin
      if (!reset_n || tick) begin
         pre_q <= '0;
      end else begin
         pre_q <= pre_q + 1'b1;
      end
   end

   assign wr = sel_i && iow_i && ofs_i == TIMER2_OFS;

   // reload register, lsb then msb
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         hi_next_q   <= 1'b0;
         load_pend_q <= 1'b0;
         reload_q    <= 16'h0000;
      end else begin
         load_pend_q <= 1'b0;
         if (wr && !hi_next_q) begin
            reload_q[7:0] <= wdata_i;
            hi_next_q     <= 1'b1;
         end else if (wr) begin
            reload_q[15:8] <= wdata_i;
            hi_next_q      <= 1'b0;
            load_pend_q    <= 1'b1;   // counter picks it up next cycle
         end
      end
   end

   // square wave, output flips every reload ticks
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         cnt_q      <= 16'h0000;
         tim2_out_o <= 1'b1;
      end else if (!gate_i) begin
         cnt_q      <= reload_q;   // gate low holds out high and rearms
         tim2_out_o <= 1'b1;
      end else if (load_pend_q) begin
         cnt_q <= reload_q;
      end else if (tick) begin
         if (cnt_q == 16'd1) begin
            cnt_q      <= reload_q;
            tim2_out_o <= ~tim2_out_o;
         end else begin
            cnt_q <= cnt_q - 1'b1;   // 0 wraps, so 0 means 65536
         end
      end
   end

   assign speaker_o = tim2_out_o && spkr_data_i;

   // a count of zero runs on through ffff rather than flipping the output
   reload_zero_full: assert property (@(posedge clk) disable iff (!reset_n)
      tick && gate_i && !load_pend_q && cnt_q == 16'd0
      |=> cnt_q == 16'hFFFF && $stable(tim2_out_o));

endmodule

/* pc_glue_top.sv */
`timescale 1ns/1ps

module pc_glue_top
   import pc_glue_pkg::*;
#(
   parameter int         TICK_DIV = 4,
   parameter logic [7:0] SW1      = 8'hA5,
   parameter logic [3:0] SW2      = 4'h9
) (
   input  logic        clk,
   input  logic        reset_n,
   input  logic [9:0]  xa_i,
   input  logic        iow_i,
   input  logic        ior_i,
   input  logic [7:0]  wdata_i,
   input  logic [19:0] mem_a_i,
   input  logic        memr_i,
   input  logic        memw_i,
   input  logic        io_ch_ck_n_i,
   input  logic        parity_err_i,
   output logic [7:0]  rdata_o,
   output logic [7:0]  rom_cs_n_o,
   output logic [3:0]  ram_ras_n_o,
   output logic        nmi_o,
   output logic        speaker_o
);

   logic       timer_sel, ppi_sel, nmi_sel;
   logic [1:0] ofs;
   logic [7:0] port_b;
   logic [7:0] ppi_rdata;
   logic       tim2_out;
   logic       iock_flag, pck_flag;

   addr_decoder addr_decoder_inst (
      .xa_i(xa_i), .mem_a_i(mem_a_i), .memr_i(memr_i), .memw_i(memw_i),
      .timer_sel_o(timer_sel), .ppi_sel_o(ppi_sel), .nmi_sel_o(nmi_sel),
      .ofs_o(ofs), .rom_cs_n_o(rom_cs_n_o), .ram_ras_n_o(ram_ras_n_o)
   );

   nmi_control nmi_control_inst (
      .clk(clk), .reset_n(reset_n), .sel_i(nmi_sel), .iow_i(iow_i),
      .wdata_i(wdata_i), .io_ch_ck_n_i(io_ch_ck_n_i), .parity_err_i(parity_err_i),
      .memr_i(memr_i), .enb_iock_n_i(port_b[PB_ENB_IOCK_N]),
      .enb_pck_n_i(port_b[PB_ENB_PCK_N]),
      .nmi_o(nmi_o), .iock_flag_o(iock_flag), .pck_flag_o(pck_flag)
   );

   system_ports #(.SW1(SW1), .SW2(SW2)) system_ports_inst (
      .clk(clk), .reset_n(reset_n), .sel_i(ppi_sel), .iow_i(iow_i), .ofs_i(ofs),
      .wdata_i(wdata_i), .tim2_out_i(tim2_out), .iock_flag_i(iock_flag),
      .pck_flag_i(pck_flag), .port_b_o(port_b), .rdata_o(ppi_rdata)
   );

   speaker_timer #(.TICK_DIV(TICK_DIV)) speaker_timer_inst (
      .clk(clk), .reset_n(reset_n), .sel_i(timer_sel), .iow_i(iow_i), .ofs_i(ofs),
      .wdata_i(wdata_i), .gate_i(port_b[PB_TIM2_GATE]),
      .spkr_data_i(port_b[PB_SPKR_DATA]),
      .tim2_out_o(tim2_out), .speaker_o(speaker_o)
   );

   // only the PPI block has readable ports left
   assign rdata_o = (ior_i && ppi_sel) ? ppi_rdata : 8'h00;

endmodule

/* pc_glue_tests.svh */
`ifndef PC_GLUE_TESTS_SVH
`define PC_GLUE_TESTS_SVH

task automatic decode_memory();
   logic [19:0] a;
   logic [7:0]  exp_rom;
   logic [3:0]  exp_ras;
   logic        rd, wr;
   for (int i = 0; i < 64; i++) begin
      a = 20'($urandom);
      case ($urandom_range(0, 2))
         0: a[19:16] = ROM_SEG;
         1: a[19:18] = RAM_SEG_BITS;
         default: ;   // anywhere in the map
      endcase
      rd = 1'($urandom);
      wr = 1'($urandom);
      @(negedge clk);
      mem_a_i = a;
      memr_i  = rd;
      memw_i  = wr;
      exp_rom = (a[19:16] == ROM_SEG && rd) ? ~(8'd1 << a[15:13]) : 8'hFF;
      exp_ras = (a[19:18] == RAM_SEG_BITS && (rd || wr)) ? ~(4'd1 << a[17:16]) : 4'hF;
      @(posedge clk);
      check_value($sformatf("rom_cs_n at %05h", a), rom_cs_n_o, exp_rom);
      check_value($sformatf("ram_ras_n at %05h", a), ram_ras_n_o, exp_ras);
   end
   @(negedge clk);
   memr_i = 1'b0;
   memw_i = 1'b0;
endtask

task automatic read_ports();
   logic [7:0] d, v;
   v = 8'($urandom);
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), v);
   io_read(port_addr(IO_BLK_PPI, PORT_B_OFS), d);
   check_value("port B readback", d, v);
   io_read(port_addr(IO_BLK_PPI, PORT_A_OFS), d);
   check_value("port A switches", d, 8'hA5);
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h00);
   io_read(port_addr(IO_BLK_PPI, PORT_C_OFS), d);
   check_value("port C low switches", d[3:0], 4'h1);   // SW2[1:0]
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h04);
   io_read(port_addr(IO_BLK_PPI, PORT_C_OFS), d);
   check_value("port C high switches", d[3:0], 4'h2);  // SW2[3:2]
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h00);
endtask

task automatic wait_nmi_level(input logic level);
   int n;
   for (n = 0; n < 50 && nmi_o !== level; n++) @(negedge clk);
   if (nmi_o !== level) begin
      errors++;
      $display("timeout at %0t ns: nmi_o never went to %0b", $time, level);
   end
endtask

task automatic nmi_sources();
   logic [7:0] d;
   io_write(port_addr(IO_BLK_NMI, 2'd0), 8'h00);
   @(negedge clk);
   io_ch_ck_n_i = 1'b0;
   repeat (4) @(negedge clk);
   check_value("nmi with mask clear, iock", nmi_o, 1'b0);
   io_write(port_addr(IO_BLK_NMI, 2'd0), 8'h80);
   wait_nmi_level(1'b1);
   io_read(port_addr(IO_BLK_PPI, PORT_C_OFS), d);
   check_value("port C iock bit", d[PC_IOCK], 1'b1);
   io_ch_ck_n_i = 1'b1;
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h20);   // disable and clear
   wait_nmi_level(1'b0);
   io_read(port_addr(IO_BLK_PPI, PORT_C_OFS), d);
   check_value("port C iock cleared", d[PC_IOCK], 1'b0);
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h00);
   io_write(port_addr(IO_BLK_NMI, 2'd0), 8'h00);
   // same again for a parity error on a memory read
   parity_err_i = 1'b1;
   memr_i       = 1'b1;
   @(negedge clk);
   parity_err_i = 1'b0;
   memr_i       = 1'b0;
   repeat (3) @(negedge clk);
   check_value("nmi with mask clear, parity", nmi_o, 1'b0);
   io_write(port_addr(IO_BLK_NMI, 2'd0), 8'h80);
   wait_nmi_level(1'b1);
   io_read(port_addr(IO_BLK_PPI, PORT_C_OFS), d);
   check_value("port C parity bit", d[PC_PCK], 1'b1);
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h10);
   wait_nmi_level(1'b0);
   io_read(port_addr(IO_BLK_PPI, PORT_C_OFS), d);
   check_value("port C parity cleared", d[PC_PCK], 1'b0);
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h00);
   io_write(port_addr(IO_BLK_NMI, 2'd0), 8'h00);
endtask

task automatic wait_speaker_edge(output int cycles);
   logic prev;
   prev = speaker_o;
   for (cycles = 0; cycles < 200 && speaker_o === prev; cycles++) @(negedge clk);
   if (speaker_o === prev) begin
      errors++;
      $display("timeout at %0t ns: speaker_o stopped toggling", $time);
   end
endtask

task automatic speaker_tone();
   int cyc, highs;
   io_write(port_addr(IO_BLK_TIMER, TIMER2_OFS), 8'd5);   // low byte first
   io_write(port_addr(IO_BLK_TIMER, TIMER2_OFS), 8'd0);
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h03);    // gate and data on
   wait_speaker_edge(cyc);   // line up with the waveform
   for (int i = 0; i < 2; i++) begin
      wait_speaker_edge(cyc);
      check_value($sformatf("half period of %0d cycles in 16..24", cyc),
                  (cyc >= 16 && cyc <= 24), 1'b1);
   end
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h01);    // data off
   highs = 0;
   repeat (60) begin
      @(negedge clk);
      if (speaker_o !== 1'b0) highs++;
   end
   check_value("speaker cycles high with data off", highs, 0);
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h00);
endtask

task automatic gate_low_idle();
   logic [7:0] d, pc_before;
   for (int i = 0; i < 10; i++) begin
      repeat (5) @(negedge clk);
      io_read(port_addr(IO_BLK_PPI, PORT_C_OFS), d);
      check_value("tim2_out with gate low", d[PC_TIM2_OUT], 1'b1);
   end
   // latched channel check, so a stray mask write would raise nmi
   io_ch_ck_n_i = 1'b0;
   io_read(port_addr(IO_BLK_PPI, PORT_C_OFS), pc_before);
   check_value("iock latched before stray writes", pc_before[PC_IOCK], 1'b1);
   for (int b = 0; b < 32; b++) begin
      if (b == IO_BLK_TIMER || b == IO_BLK_PPI || b == IO_BLK_NMI) continue;
      io_write(port_addr(5'(b), PORT_B_OFS), 8'($urandom) | 8'h80);
   end
   io_read(port_addr(IO_BLK_PPI, PORT_B_OFS), d);
   check_value("port B after stray writes", d, 8'h00);
   io_read(port_addr(IO_BLK_PPI, PORT_C_OFS), d);
   check_value("port C after stray writes", d, pc_before);
   check_value("nmi after stray writes", nmi_o, 1'b0);
   io_ch_ck_n_i = 1'b1;
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h20);   // drop the iock flag
   io_write(port_addr(IO_BLK_PPI, PORT_B_OFS), 8'h00);
endtask

`endif

/* tb_pc_glue.sv */
`timescale 1ns/1ps

module tb_pc_glue
   import pc_glue_pkg::*;
();

   logic        clk;
   logic        reset_n;
   io_addr_u    xa;
   logic        iow_i, ior_i;
   logic [7:0]  wdata_i;
   logic [19:0] mem_a_i;
   logic        memr_i, memw_i;
   logic        io_ch_ck_n_i, parity_err_i;
   logic [7:0]  rdata_o, rom_cs_n_o;
   logic [3:0]  ram_ras_n_o;
   logic        nmi_o, speaker_o;

   int errors;
   int checks;
   int tests_run;
   int errors_at_start;   // error count when the current test began

   pc_glue_top #(.TICK_DIV(4), .SW1(8'hA5), .SW2(4'h9)) pc_glue_top_inst (
      .clk(clk), .reset_n(reset_n), .xa_i(xa.raw), .iow_i(iow_i), .ior_i(ior_i),
      .wdata_i(wdata_i), .mem_a_i(mem_a_i), .memr_i(memr_i), .memw_i(memw_i),
      .io_ch_ck_n_i(io_ch_ck_n_i), .parity_err_i(parity_err_i), .rdata_o(rdata_o),
      .rom_cs_n_o(rom_cs_n_o), .ram_ras_n_o(ram_ras_n_o), .nmi_o(nmi_o),
      .speaker_o(speaker_o)
   );

   always #20 clk = ~clk;   // 40 ns period

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // raw I/O address from block and port offset
   function automatic logic [9:0] port_addr(input logic [4:0] blk, input logic [1:0] ofs);
      return {blk, 3'b000, ofs};
   endfunction

   task automatic io_write(input logic [9:0] addr, input logic [7:0] data);
      @(negedge clk);
      xa.raw  = addr;
      wdata_i = data;
      iow_i   = 1'b1;   // one cycle pulse
      @(negedge clk);
      iow_i   = 1'b0;
   endtask

   task automatic io_read(input logic [9:0] addr, output logic [7:0] data);
      @(negedge clk);
      xa.raw = addr;
      ior_i  = 1'b1;
      @(negedge clk);
      data  = rdata_o;   // taken mid cycle, away from the register edge
      ior_i = 1'b0;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      $display("%s: %0d errors", name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   `include "pc_glue_tests.svh"

   initial begin
      void'($urandom(32'hf673_d993));
      clk          = 1'b0;
      reset_n      = 1'b0;
      xa.raw       = '0;
      iow_i        = 1'b0;
      ior_i        = 1'b0;
      wdata_i      = '0;
      mem_a_i      = '0;
      memr_i       = 1'b0;
      memw_i       = 1'b0;
      io_ch_ck_n_i = 1'b1;
      parity_err_i = 1'b0;
      errors          = 0;
      checks          = 0;
      tests_run       = 0;
      errors_at_start = 0;
      repeat (16) @(negedge clk);
      reset_n = 1'b1;

      decode_memory();
      finish_test("memory decode");
      read_ports();
      finish_test("port readback");
      nmi_sources();
      finish_test("nmi");
      speaker_tone();
      finish_test("speaker");
      gate_low_idle();
      finish_test("gate low");

      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* tb.f */
+incdir+.
pc_glue_pkg.sv
addr_decoder.sv
nmi_control.sv
system_ports.sv
speaker_timer.sv
pc_glue_top.sv
tb_pc_glue.sv

/* Bender.yml */
package:
  name: pc_glue

sources:
  - files:
      - pc_glue_pkg.sv
      - addr_decoder.sv
      - nmi_control.sv
      - system_ports.sv
      - speaker_timer.sv
      - pc_glue_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pc_glue.sv
